//--- common/cpu_types_pkg.sv
package cpu_types_pkg;

  parameter int WORD_W = 32;

  typedef logic [WORD_W-1:0] word_t;
  typedef logic [4:0]        regbits_t;

  parameter regbits_t LINK_REG = 5'd31; // jal writes here

  // major opcodes, instruction[31:26]
  typedef enum logic [5:0] {
    RTYPE = 6'h00,
    J     = 6'h02,
    JAL   = 6'h03,
    BEQ   = 6'h04,
    BNE   = 6'h05,
    ADDIU = 6'h09,
    SLTI  = 6'h0a,
    ANDI  = 6'h0c,
    ORI   = 6'h0d,
    XORI  = 6'h0e,
    LUI   = 6'h0f,
    LW    = 6'h23,
    SW    = 6'h2b,
    HALT  = 6'h3f
  } opcode_t;

  // r-type function field, instruction[5:0]
  typedef enum logic [5:0] {
    SLL  = 6'h00,
    SRL  = 6'h02,
    JR   = 6'h08,
    ADDU = 6'h21,
    SUBU = 6'h23,
    AND  = 6'h24,
    OR   = 6'h25,
    XOR  = 6'h26,
    NOR  = 6'h27,
    SLT  = 6'h2a,
    SLTU = 6'h2b
  } funct_t;

  typedef enum logic [3:0] {
    ALU_SLL,
    ALU_SRL,
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_NOR,
    ALU_SLT,
    ALU_SLTU,
    ALU_LUI   // immediate into upper half
  } aluop_t;

endpackage

//--- common/pipe_ctrl_pkg.sv
package pipe_ctrl_pkg;

  // where an operand comes from when a newer producer is in flight
  typedef enum logic [1:0] {
    NONE,     // register file or latched value
    MEM_ALU,  // ex/mem result
    WB_DATA,  // writeback value
    MEM_LOAD  // load data of this cycle
  } fwd_sel_t;

  typedef enum logic [1:0] {
    SEQ,
    BRANCH,
    JUMP,
    JREG
  } pcsrc_t;

  typedef enum logic [1:0] {
    RT,
    RD,
    LINK
  } regdst_t;

  typedef enum logic [1:0] {
    ALU,
    LOAD,
    PCN    // return address for jal
  } memtoreg_t;

  typedef enum logic [1:0] {
    REG,
    IMM,
    SHAMT
  } alusrc_t;

endpackage

//--- source/alu.sv
module alu (
  input  cpu_types_pkg::aluop_t op,
  input  cpu_types_pkg::word_t  port_a,
  input  cpu_types_pkg::word_t  port_b,
  output cpu_types_pkg::word_t  result,
  output logic                  zero,
  output logic                  negative,
  output logic                  overflow
);
  import cpu_types_pkg::*;

  always_comb begin
    case (op)
      ALU_SLL:  result = port_a << port_b[4:0];
      ALU_SRL:  result = port_a >> port_b[4:0];
      ALU_ADD:  result = port_a + port_b;
      ALU_SUB:  result = port_a - port_b;
      ALU_AND:  result = port_a & port_b;
      ALU_OR:   result = port_a | port_b;
      ALU_XOR:  result = port_a ^ port_b;
      ALU_NOR:  result = ~(port_a | port_b);
      ALU_SLT:  result = {31'b0, $signed(port_a) < $signed(port_b)};
      ALU_SLTU: result = {31'b0, port_a < port_b};
      ALU_LUI:  result = {port_b[15:0], 16'h0000};
      default:  result = '0;
    endcase
  end

  assign zero     = (result == '0);
  assign negative = result[WORD_W-1];

  // signed overflow, add and sub only
  always_comb begin
    case (op)
      ALU_ADD: overflow = (port_a[31] == port_b[31]) && (result[31] != port_a[31]);
      ALU_SUB: overflow = (port_a[31] != port_b[31]) && (result[31] != port_a[31]);
      default: overflow = 1'b0;
    endcase
  end

endmodule

//--- source/register_file.sv
module register_file (
  input  logic                    CLK,
  input  logic                    nRST,
  input  logic                    wen,
  input  cpu_types_pkg::regbits_t wsel,
  input  cpu_types_pkg::regbits_t rsel1,
  input  cpu_types_pkg::regbits_t rsel2,
  input  cpu_types_pkg::word_t    wdat,
  output cpu_types_pkg::word_t    rdat1,
  output cpu_types_pkg::word_t    rdat2
);
  import cpu_types_pkg::*;

  word_t regs [32];
  logic  wr_live;

  assign wr_live = wen && (wsel != '0); // $zero never written

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_live) begin
      regs[wsel] <= wdat;
    end
  end

  // writeback in the same cycle as decode reads the new value
  assign rdat1 = (wr_live && wsel == rsel1) ? wdat : regs[rsel1];
  assign rdat2 = (wr_live && wsel == rsel2) ? wdat : regs[rsel2];

endmodule

//--- source/control_unit.sv
module control_unit (
  input  cpu_types_pkg::word_t      instruction,
  output cpu_types_pkg::aluop_t     alu_op,
  output pipe_ctrl_pkg::alusrc_t    alu_src,
  output pipe_ctrl_pkg::regdst_t    reg_dst,
  output pipe_ctrl_pkg::memtoreg_t  mem_to_reg,
  output pipe_ctrl_pkg::pcsrc_t     pc_src,
  output logic                      reg_wr,
  output logic                      mem_rd,
  output logic                      mem_wr,
  output logic                      branch,
  output logic                      branch_neq,
  output logic                      ext_sign,
  output logic                      halt,
  output cpu_types_pkg::regbits_t   rs,
  output cpu_types_pkg::regbits_t   rt,
  output cpu_types_pkg::regbits_t   rd,
  output logic [4:0]                shamt,
  output logic [15:0]               imm16,
  output logic [25:0]               imm26
);
  import cpu_types_pkg::*;
  import pipe_ctrl_pkg::*;

  opcode_t opcode;
  funct_t  funct;

  assign opcode = opcode_t'(instruction[31:26]);
  assign funct  = funct_t'(instruction[5:0]);
  assign rs     = instruction[25:21];
  assign rt     = instruction[20:16];
  assign rd     = instruction[15:11];
  assign shamt  = instruction[10:6];
  assign imm16  = instruction[15:0];
  assign imm26  = instruction[25:0];

  always_comb begin
    // defaults describe a no-op
    alu_op     = ALU_ADD;
    alu_src    = REG;
    reg_dst    = RT;
    mem_to_reg = ALU;
    pc_src     = SEQ;
    reg_wr     = 1'b0;
    mem_rd     = 1'b0;
    mem_wr     = 1'b0;
    branch     = 1'b0;
    branch_neq = 1'b0;
    ext_sign   = 1'b0;
    halt       = 1'b0;
    case (opcode)
      RTYPE: begin
        reg_dst = RD;
        reg_wr  = 1'b1;
        case (funct)
          SLL: begin
            alu_op  = ALU_SLL;
            alu_src = SHAMT;
          end
          SRL: begin
            alu_op  = ALU_SRL;
            alu_src = SHAMT;
          end
          JR: begin
            pc_src = JREG;
            reg_wr = 1'b0;
          end
          ADDU:    alu_op = ALU_ADD;
          SUBU:    alu_op = ALU_SUB;
          AND:     alu_op = ALU_AND;
          OR:      alu_op = ALU_OR;
          XOR:     alu_op = ALU_XOR;
          NOR:     alu_op = ALU_NOR;
          SLT:     alu_op = ALU_SLT;
          SLTU:    alu_op = ALU_SLTU;
          default: reg_wr = 1'b0; // unknown funct does nothing
        endcase
      end
      ADDIU, SLTI, ANDI, ORI, XORI, LUI: begin
        alu_src  = IMM;
        reg_wr   = 1'b1;
        ext_sign = (opcode == ADDIU) || (opcode == SLTI);
        case (opcode)
          SLTI:    alu_op = ALU_SLT;
          ANDI:    alu_op = ALU_AND;
          ORI:     alu_op = ALU_OR;
          XORI:    alu_op = ALU_XOR;
          LUI:     alu_op = ALU_LUI;
          default: alu_op = ALU_ADD;
        endcase
      end
      LW: begin
        alu_src    = IMM;
        ext_sign   = 1'b1;
        reg_wr     = 1'b1;
        mem_rd     = 1'b1;
        mem_to_reg = LOAD;
      end
      SW: begin
        alu_src  = IMM;
        ext_sign = 1'b1;
        mem_wr   = 1'b1;
      end
      BEQ:  branch     = 1'b1; // datapath decides taken
      BNE:  branch_neq = 1'b1;
      J:    pc_src     = JUMP;
      JAL: begin
        pc_src     = JUMP;
        reg_wr     = 1'b1;
        reg_dst    = LINK;
        mem_to_reg = PCN;
      end
      HALT:    halt = 1'b1;
      default: ;
    endcase
  end

endmodule

//--- datapath/forward_unit.sv
module forward_unit (
  input  cpu_types_pkg::regbits_t  id_rs,
  input  cpu_types_pkg::regbits_t  id_rt,
  input  cpu_types_pkg::regbits_t  ex_rs,
  input  cpu_types_pkg::regbits_t  ex_rt,
  input  cpu_types_pkg::regbits_t  mem_rd,
  input  cpu_types_pkg::regbits_t  wb_rd,
  input  logic                     mem_reg_wr,
  input  logic                     wb_reg_wr,
  input  logic                     mem_mem_rd,
  output pipe_ctrl_pkg::fwd_sel_t  fwd_a,
  output pipe_ctrl_pkg::fwd_sel_t  fwd_b,
  output pipe_ctrl_pkg::fwd_sel_t  fwd_id1,
  output pipe_ctrl_pkg::fwd_sel_t  fwd_id2
);
  import cpu_types_pkg::*;
  import pipe_ctrl_pkg::*;

  // youngest producer wins, mem before wb
  function automatic fwd_sel_t pick(input regbits_t src);
    if (src == '0) begin
      return NONE;
    end else if (mem_reg_wr && mem_rd == src) begin
      return mem_mem_rd ? MEM_LOAD : MEM_ALU;
    end else if (wb_reg_wr && wb_rd == src) begin
      return WB_DATA;
    end
    return NONE;
  endfunction

  always_comb begin
    fwd_a   = pick(ex_rs);
    fwd_b   = pick(ex_rt);   // also the store data
    fwd_id1 = pick(id_rs);   // decode compare and jr target
    fwd_id2 = pick(id_rt);
  end

endmodule

//--- datapath/hazard_unit.sv
module hazard_unit (
  input  cpu_types_pkg::regbits_t id_rs,
  input  cpu_types_pkg::regbits_t id_rt,
  input  cpu_types_pkg::regbits_t ex_rd,
  input  logic                    ex_mem_rd,
  input  logic                    id_branch,
  input  logic                    id_jreg,
  input  logic                    redirect,
  output logic                    stall_id,
  output logic                    flush_ifid,
  output logic                    flush_idex,
  output logic                    pc_en
);
  logic ex_match;
  logic load_use;
  logic cmp_dep;

  // ex_rd is zero unless execute writes a register
  assign ex_match = (ex_rd != '0) && (ex_rd == id_rs || ex_rd == id_rt);

  assign load_use = ex_mem_rd && ex_match;

  // decode compare cannot see an alu result still in execute
  assign cmp_dep = (id_branch || id_jreg) && ex_match;

  assign stall_id   = load_use || cmp_dep;
  assign flush_idex = stall_id;              // bubble behind the stalled op
  assign flush_ifid = redirect && !stall_id;
  assign pc_en      = !stall_id;

endmodule

//--- datapath/datapath.sv
module datapath #(
  parameter cpu_types_pkg::word_t PC_INIT = 32'h0
) (
  input  logic                 CLK,
  input  logic                 nRST,
  input  logic                 ihit,
  input  logic                 dhit,
  input  cpu_types_pkg::word_t imemload,
  input  cpu_types_pkg::word_t dmemload,
  output logic                 imemREN,
  output logic                 dmemREN,
  output logic                 dmemWEN,
  output logic                 halt,
  output cpu_types_pkg::word_t imemaddr,
  output cpu_types_pkg::word_t dmemaddr,
  output cpu_types_pkg::word_t dmemstore
);
  import cpu_types_pkg::*;
  import pipe_ctrl_pkg::*;

  word_t     pc, pc_next4, next_pc;
  logic      en, mem_wait, fetch_stop;
  logic      ifid_valid;
  word_t     ifid_instr, ifid_pcn;
  aluop_t    id_alu_op;
  alusrc_t   id_alu_src;
  regdst_t   id_reg_dst;
  memtoreg_t id_mem_to_reg;
  pcsrc_t    id_pc_src, pc_src;
  logic      id_reg_wr, id_mem_rd, id_mem_wr, id_branch, id_branch_neq, id_ext_sign, id_halt;
  regbits_t  id_rs, id_rt, id_rd, id_dest, ex_wr_dest;
  logic [4:0]  id_shamt;
  logic [15:0] id_imm16;
  logic [25:0] id_imm26;
  word_t     rdat1, rdat2, id_op1, id_op2, id_imm;
  logic      taken, redirect;
  fwd_sel_t  fwd_a, fwd_b, fwd_id1, fwd_id2;
  logic      stall_id, flush_ifid, flush_idex, pc_en;
  logic      idex_valid, idex_reg_wr, idex_mem_rd, idex_mem_wr, idex_halt;
  aluop_t    idex_alu_op;
  alusrc_t   idex_alu_src;
  memtoreg_t idex_mem_to_reg;
  regbits_t  idex_rs, idex_rt, idex_dest;
  logic [4:0] idex_shamt;
  word_t     idex_pcn, idex_rdat1, idex_rdat2, idex_imm;
  word_t     ex_op_a, ex_op_b, alu_a, alu_b, alu_out, ex_result;
  logic      exmem_valid, exmem_reg_wr, exmem_mem_rd, exmem_mem_wr, exmem_halt;
  memtoreg_t exmem_mem_to_reg;
  regbits_t  exmem_dest;
  word_t     exmem_result, exmem_store;
  logic      memwb_valid, memwb_reg_wr, memwb_halt;
  memtoreg_t memwb_mem_to_reg;
  regbits_t  memwb_dest;
  word_t     memwb_result, memwb_load, wb_data;

  control_unit cu_i (
    .instruction(ifid_instr), .alu_op(id_alu_op), .alu_src(id_alu_src),
    .reg_dst(id_reg_dst), .mem_to_reg(id_mem_to_reg), .pc_src(id_pc_src),
    .reg_wr(id_reg_wr), .mem_rd(id_mem_rd), .mem_wr(id_mem_wr), .branch(id_branch),
    .branch_neq(id_branch_neq), .ext_sign(id_ext_sign), .halt(id_halt),
    .rs(id_rs), .rt(id_rt), .rd(id_rd), .shamt(id_shamt), .imm16(id_imm16), .imm26(id_imm26)
  );

  register_file rf_i (
    .CLK, .nRST, .wen(memwb_valid && memwb_reg_wr), .wsel(memwb_dest),
    .rsel1(id_rs), .rsel2(id_rt), .wdat(wb_data), .rdat1, .rdat2
  );

  forward_unit fwu_i (
    .id_rs, .id_rt, .ex_rs(idex_rs), .ex_rt(idex_rt), .mem_rd(exmem_dest),
    .wb_rd(memwb_dest), .mem_reg_wr(exmem_reg_wr), .wb_reg_wr(memwb_reg_wr),
    .mem_mem_rd(exmem_mem_rd), .fwd_a, .fwd_b, .fwd_id1, .fwd_id2
  );

  hazard_unit hzu_i (
    .id_rs, .id_rt, .ex_rd(ex_wr_dest), .ex_mem_rd(idex_mem_rd),
    .id_branch(ifid_valid && (id_branch || id_branch_neq)),
    .id_jreg(ifid_valid && id_pc_src == JREG), .redirect,
    .stall_id, .flush_ifid, .flush_idex, .pc_en
  );

  alu alu_i (
    .op(idex_alu_op), .port_a(alu_a), .port_b(alu_b), .result(alu_out),
    .zero(), .negative(), .overflow()
  );

  // dmemload only counts in the dhit cycle; otherwise mem_wait holds everything
  function automatic word_t fwd_pick(input fwd_sel_t sel, input word_t own);
    case (sel)
      MEM_ALU:  return exmem_result;
      WB_DATA:  return wb_data;
      MEM_LOAD: return dmemload;
      default:  return own;
    endcase
  endfunction

  assign mem_wait   = (dmemREN || dmemWEN) && !dhit;
  assign en         = !mem_wait && !halt;   // halt freezes the whole pipe
  assign fetch_stop = (ifid_valid && id_halt) || idex_halt || exmem_halt || memwb_halt;
  assign imemREN    = !fetch_stop;
  assign imemaddr   = pc;
  assign pc_next4   = pc + 32'd4;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      pc <= PC_INIT;
    end else if (en && pc_en) begin
      if (redirect) begin
        pc <= next_pc;
      end else if (ihit && !fetch_stop) begin
        pc <= pc_next4;
      end
    end
  end

  // IF/ID, a missed fetch enters as a bubble
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      ifid_valid <= 1'b0;
    end else if (en && !stall_id) begin
      ifid_valid <= ihit && !flush_ifid && !fetch_stop;
    end
  end

  always_ff @(posedge CLK) begin
    if (en && !stall_id) begin
      ifid_instr <= imemload;
      ifid_pcn   <= pc_next4;
    end
  end

  always_comb begin
    id_op1 = fwd_pick(fwd_id1, rdat1);
    id_op2 = fwd_pick(fwd_id2, rdat2);
  end

  assign id_imm   = id_ext_sign ? {{16{id_imm16[15]}}, id_imm16} : {16'h0000, id_imm16};
  assign taken    = ifid_valid && ((id_branch && id_op1 == id_op2)
                                   || (id_branch_neq && id_op1 != id_op2));
  assign pc_src   = taken ? BRANCH : (ifid_valid ? id_pc_src : SEQ);
  assign redirect = (pc_src != SEQ);

  always_comb begin
    case (pc_src)
      BRANCH:  next_pc = ifid_pcn + {{14{id_imm16[15]}}, id_imm16, 2'b00};
      JUMP:    next_pc = {ifid_pcn[31:28], id_imm26, 2'b00};
      JREG:    next_pc = id_op1;
      default: next_pc = pc_next4;
    endcase
  end

  always_comb begin
    case (id_reg_dst)
      RD:      id_dest = id_rd;
      LINK:    id_dest = LINK_REG;
      default: id_dest = id_rt;
    endcase
  end

  // ID/EX
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      {idex_valid, idex_reg_wr, idex_mem_rd, idex_mem_wr, idex_halt} <= '0;
    end else if (en) begin
      if (flush_idex || !ifid_valid) begin
        {idex_valid, idex_reg_wr, idex_mem_rd, idex_mem_wr, idex_halt} <= '0;
      end else begin
        {idex_valid, idex_reg_wr, idex_mem_rd, idex_mem_wr, idex_halt} <=
          {1'b1, id_reg_wr, id_mem_rd, id_mem_wr, id_halt};
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (en) begin
      idex_alu_op     <= id_alu_op;
      idex_alu_src    <= id_alu_src;
      idex_mem_to_reg <= id_mem_to_reg;
      idex_rs         <= id_rs;
      idex_rt         <= id_rt;
      idex_dest       <= id_dest;
      idex_shamt      <= id_shamt;
      idex_pcn        <= ifid_pcn;  // link value for jal
      idex_rdat1      <= id_op1;
      idex_rdat2      <= id_op2;
      idex_imm        <= id_imm;
    end
  end

  assign ex_wr_dest = idex_reg_wr ? idex_dest : '0;

  always_comb begin
    ex_op_a = fwd_pick(fwd_a, idex_rdat1);
    ex_op_b = fwd_pick(fwd_b, idex_rdat2);
    alu_a   = ex_op_a;
    alu_b   = ex_op_b;
    case (idex_alu_src)
      IMM: alu_b = idex_imm;
      SHAMT: begin
        alu_a = ex_op_b;  // shifts act on rt
        alu_b = {27'b0, idex_shamt};
      end
      default: ;
    endcase
  end

  assign ex_result = (idex_mem_to_reg == PCN) ? idex_pcn : alu_out;

  // EX/MEM
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      {exmem_valid, exmem_reg_wr, exmem_mem_rd, exmem_mem_wr, exmem_halt} <= '0;
    end else if (en) begin
      {exmem_valid, exmem_reg_wr, exmem_mem_rd, exmem_mem_wr, exmem_halt} <=
        idex_valid ? {1'b1, idex_reg_wr, idex_mem_rd, idex_mem_wr, idex_halt} : 5'b0;
    end
  end

  always_ff @(posedge CLK) begin
    if (en) begin
      exmem_mem_to_reg <= idex_mem_to_reg;
      exmem_dest       <= idex_dest;
      exmem_result     <= ex_result;
      exmem_store      <= ex_op_b;
    end
  end

  // request held as a level until dhit
  assign dmemREN   = exmem_mem_rd;
  assign dmemWEN   = exmem_mem_wr;
  assign dmemaddr  = exmem_result;
  assign dmemstore = exmem_store;

  // MEM/WB
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      {memwb_valid, memwb_reg_wr, memwb_halt} <= '0;
    end else if (en) begin
      {memwb_valid, memwb_reg_wr, memwb_halt} <=
        exmem_valid ? {1'b1, exmem_reg_wr, exmem_halt} : 3'b0;
    end
  end

  always_ff @(posedge CLK) begin
    if (en) begin
      memwb_mem_to_reg <= exmem_mem_to_reg;
      memwb_dest       <= exmem_dest;
      memwb_result     <= exmem_result;
      memwb_load       <= dmemload;
    end
  end

  assign wb_data = (memwb_mem_to_reg == LOAD) ? memwb_load : memwb_result;
  assign halt    = memwb_halt;

endmodule

//--- tests/datapath_assert.sv
module datapath_assert (
  input logic                 CLK,
  input logic                 nRST,
  input logic                 dmemREN,
  input logic                 dmemWEN,
  input logic                 dhit,
  input logic                 halt,
  input cpu_types_pkg::word_t dmemaddr,
  input cpu_types_pkg::word_t dmemstore,
  input cpu_types_pkg::word_t imemaddr
);
  timeunit 1ns;
  timeprecision 100ps;

  one_request: assert property (@(posedge CLK) disable iff (!nRST) !(dmemREN && dmemWEN))
    else $error("data read and write requested together");

  // a waiting request keeps its address and data
  request_held: assert property (@(posedge CLK) disable iff (!nRST)
    (dmemREN || dmemWEN) && !dhit |=> $stable(dmemaddr) && $stable(dmemstore))
    else $error("data request changed before dhit");

  pc_frozen: assert property (@(posedge CLK) disable iff (!nRST) halt |=> $stable(imemaddr))
    else $error("pc moved while halted");

endmodule

bind datapath datapath_assert datapath_assert_i (.*);

//--- tests/tb_datapath.sv
module tb_datapath;
  timeunit 1ns;
  timeprecision 100ps;
  import cpu_types_pkg::*;

  localparam word_t PC_INIT = 32'h0000_0100;
  localparam int BASE_IDX = int'(PC_INIT >> 2);  // first program word in imem
  localparam int HALT_LIMIT = 3000;

  logic  CLK, nRST, ihit, dhit;
  word_t imemload, dmemload, imemaddr, dmemaddr, dmemstore;
  logic  imemREN, dmemREN, dmemWEN, halt;

  word_t imem [256];
  word_t dmem [256];
  word_t exp_addr [$], exp_data [$];
  word_t got_addr [$], got_data [$];
  int    prog_idx;
  int    iwait, dwait;
  logic  rand_waits;

  datapath #(.PC_INIT(PC_INIT)) datapath_i (.*);

  always #10 CLK = ~CLK;

  // memories answer combinationally and the hit strobe says when
  assign imemload = imem[imemaddr[9:2]];
  assign dmemload = dmem[dmemaddr[9:2]];

  function automatic int next_wait();
    return rand_waits ? int'($urandom_range(3, 0)) : 0;
  endfunction

  always @(posedge CLK) begin
    if (!nRST) begin
      ihit  <= 1'b0;
      iwait <= 0;
    end else if (!imemREN) begin
      ihit <= 1'b0;  // no fetch request, no hit
    end else if (iwait == 0) begin
      ihit  <= 1'b1;
      iwait <= next_wait();
    end else begin
      ihit  <= 1'b0;
      iwait <= iwait - 1;
    end
  end

  always @(posedge CLK) begin
    if (!nRST) begin
      dhit  <= 1'b0;
      dwait <= 0;
    end else if (dhit) begin
      if (dmemWEN) begin  // log every completed store
        dmem[dmemaddr[9:2]] <= dmemstore;
        got_addr.push_back(dmemaddr);
        got_data.push_back(dmemstore);
      end
      dhit  <= 1'b0;
      dwait <= next_wait();
    end else if (dmemREN || dmemWEN) begin
      if (dwait == 0) dhit <= 1'b1;
      else dwait <= dwait - 1;
    end
  end

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("=== FAIL ===");
    $fatal(1);
  endtask

  function automatic word_t fill_word(input word_t a);
    return 32'hc0de0000 ^ (a * 32'h00010003);
  endfunction

  function automatic word_t rtype(funct_t f, regbits_t rs, regbits_t rt, regbits_t rd,
                                  logic [4:0] sh);
    return {6'h00, rs, rt, rd, sh, f};
  endfunction

  function automatic word_t itype(opcode_t op, regbits_t rs, regbits_t rt, logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic word_t jtype(opcode_t op, logic [25:0] target);
    return {op, target};
  endfunction

  task automatic begin_program();
    for (int i = 0; i < 256; i++) begin
      imem[i] = {HALT, 26'(i * 4)};  // stray fetches stop the core
      dmem[i] = fill_word(word_t'(i * 4));
    end
    prog_idx = BASE_IDX;
    exp_addr.delete();
    exp_data.delete();
  endtask

  task automatic emit(input word_t instr);
    imem[prog_idx] = instr;
    prog_idx++;
  endtask

  task automatic expect_sw(input regbits_t r, input word_t addr, input word_t val);
    emit(itype(SW, 5'd0, r, addr[15:0]));
    exp_addr.push_back(addr);
    exp_data.push_back(val);
  endtask

  task automatic op_sw(input word_t instr, input regbits_t r, input word_t addr,
                       input word_t val);
    emit(instr);
    expect_sw(r, addr, val);  // store right behind its producer
  endtask

  task automatic check_store(input word_t ea, input word_t ed, input word_t ga, input word_t gd);
    if (ea !== ga || ed !== gd) begin
      fail_now($sformatf("mismatch at %0t: store expected [%h]=%h, got [%h]=%h",
                         $time, ea, ed, ga, gd));
    end
  endtask

  task automatic check_halt(input logic got, input int stores_before);
    if (got !== 1'b1) begin
      fail_now($sformatf("mismatch at %0t: halt dropped after being set", $time));
    end
    if (got_addr.size() != stores_before) begin
      fail_now("a store appeared after the core halted");
    end
  endtask

  task automatic run_program(input string name);
    int n;
    int stores;
    nRST <= 1'b0;
    repeat (16) @(posedge CLK);
    got_addr.delete();
    got_data.delete();
    nRST <= 1'b1;
    n = 0;
    while (halt !== 1'b1) begin
      @(posedge CLK);
      n++;
      if (n > HALT_LIMIT) fail_now({name, ": core never reached halt"});
    end
    if (got_addr.size() != exp_addr.size()) begin
      fail_now($sformatf("mismatch at %0t: %s saw %0d stores but expected %0d", $time, name,
                         got_addr.size(), exp_addr.size()));
    end
    foreach (exp_addr[i]) check_store(exp_addr[i], exp_data[i], got_addr[i], got_data[i]);
    stores = got_addr.size();
    repeat (20) begin
      @(posedge CLK);
      check_halt(halt, stores);
    end
  endtask

  task automatic load_alu_program();
    begin_program();
    op_sw(itype(ADDIU, 0, 1, 16'h0005), 1, 32'h200, 32'h5);
    op_sw(itype(ADDIU, 0, 2, 16'hfffd), 2, 32'h204, 32'hfffffffd);
    op_sw(itype(LUI, 0, 3, 16'h1234), 3, 32'h208, 32'h12340000);
    op_sw(itype(ORI, 3, 3, 16'h5678), 3, 32'h20c, 32'h12345678);
    op_sw(rtype(ADDU, 1, 2, 4, 0), 4, 32'h210, 32'h2);
    op_sw(rtype(SUBU, 1, 2, 5, 0), 5, 32'h214, 32'h8);
    op_sw(rtype(XOR, 3, 2, 6, 0), 6, 32'h218, 32'hedcba985);
    op_sw(rtype(NOR, 1, 0, 7, 0), 7, 32'h21c, 32'hfffffffa);
    op_sw(rtype(SLT, 2, 1, 8, 0), 8, 32'h220, 32'h1);   // -3 < 5
    op_sw(rtype(SLTU, 2, 1, 9, 0), 9, 32'h224, 32'h0);
    op_sw(rtype(SLL, 0, 1, 10, 4), 10, 32'h228, 32'h50);
    op_sw(rtype(SRL, 0, 2, 11, 28), 11, 32'h22c, 32'hf);
    op_sw(itype(ANDI, 3, 12, 16'hff00), 12, 32'h230, 32'h5600);
    op_sw(itype(XORI, 1, 13, 16'h00ff), 13, 32'h234, 32'hfa);
    op_sw(itype(SLTI, 2, 14, 16'hfffe), 14, 32'h238, 32'h1);
    op_sw(rtype(AND, 3, 7, 15, 0), 15, 32'h23c, 32'h12345678);
    op_sw(rtype(OR, 1, 10, 16, 0), 16, 32'h240, 32'h55);
    emit({HALT, 26'h0});
  endtask

  task automatic alu_and_imm_ops();
    load_alu_program();
    run_program("alu_imm");
  endtask

  task automatic back_to_back_deps();
    begin_program();
    emit(itype(ADDIU, 0, 1, 16'h0001));
    emit(rtype(ADDU, 1, 1, 2, 0));   // ex/mem path
    emit(rtype(ADDU, 2, 1, 3, 0));   // mem and wb paths
    emit(rtype(ADDU, 3, 2, 4, 0));
    emit(rtype(SLL, 0, 4, 5, 2));
    expect_sw(1, 32'h280, 32'd1);
    expect_sw(2, 32'h284, 32'd2);
    expect_sw(3, 32'h288, 32'd3);
    expect_sw(4, 32'h28c, 32'd5);
    expect_sw(5, 32'h290, 32'd20);
    emit({HALT, 26'h0});
    run_program("forwarding");
  endtask

  task automatic load_then_use();
    begin_program();
    op_sw(itype(ADDIU, 0, 1, 16'h0077), 1, 32'h300, 32'h77);
    emit(itype(LW, 0, 2, 16'h0300));
    op_sw(itype(ADDIU, 2, 3, 16'h0001), 3, 32'h304, 32'h78);
    emit(itype(LW, 0, 4, 16'h0300));
    expect_sw(4, 32'h308, 32'h77);  // store of a just-loaded register
    emit(itype(LW, 0, 5, 16'h0340));
    op_sw(rtype(ADDU, 5, 5, 6, 0), 6, 32'h30c, fill_word(32'h340) * 2);
    emit({HALT, 26'h0});
    run_program("load_use");
  endtask

  task automatic branch_and_jump_paths();
    begin_program();
    emit(itype(ADDIU, 0, 1, 16'd5));          // 0
    emit(itype(ADDIU, 0, 2, 16'd5));          // 1
    emit(itype(BEQ, 1, 2, 16'd1));            // 2 taken
    emit(itype(SW, 0, 1, 16'h03f0));          // 3 skipped
    emit(itype(BNE, 1, 2, 16'd1));            // 4 not taken
    expect_sw(1, 32'h380, 32'd5);             // 5
    emit(itype(ADDIU, 0, 3, 16'd7));          // 6
    emit(itype(BNE, 1, 3, 16'd1));            // 7 taken
    emit(itype(SW, 0, 1, 16'h03f4));          // 8 skipped
    emit(itype(BEQ, 1, 3, 16'd1));            // 9 not taken
    expect_sw(3, 32'h384, 32'd7);             // 10
    emit(jtype(J, 26'(BASE_IDX + 13)));       // 11
    emit(itype(SW, 0, 1, 16'h03f8));          // 12 skipped
    emit(jtype(JAL, 26'(BASE_IDX + 17)));     // 13 links the word after it
    expect_sw(LINK_REG, 32'h388, PC_INIT + 32'd56);  // 14
    expect_sw(4, 32'h38c, 32'd9);             // 15
    emit({HALT, 26'h0});                      // 16
    emit(itype(ADDIU, 0, 4, 16'd9));          // 17
    emit(rtype(JR, LINK_REG, 0, 0, 0));       // 18
    run_program("branches");
  endtask

  task automatic random_wait_rerun();
    rand_waits = 1'b1;
    load_alu_program();
    run_program("random_wait");
    rand_waits = 1'b0;
  endtask

  initial begin
    void'($urandom(32'h9012cf01));
    CLK        = 1'b0;
    nRST       = 1'b0;
    ihit       = 1'b0;
    dhit       = 1'b0;
    rand_waits = 1'b0;
    begin_program();
    alu_and_imm_ops();
    back_to_back_deps();
    load_then_use();
    branch_and_jump_paths();
    random_wait_rerun();
    $display("=== PASS ===");
    $finish;
  end

endmodule

//--- cpu_pipe.f
common/cpu_types_pkg.sv
common/pipe_ctrl_pkg.sv
source/alu.sv
source/register_file.sv
source/control_unit.sv
datapath/forward_unit.sv
datapath/hazard_unit.sv
datapath/datapath.sv
tests/datapath_assert.sv
tests/tb_datapath.sv

//--- Bender.yml
package:
  name: cpu_pipe

sources:
  - files:
      - common/cpu_types_pkg.sv
      - common/pipe_ctrl_pkg.sv
      - source/alu.sv
      - source/register_file.sv
      - source/control_unit.sv
      - datapath/forward_unit.sv
      - datapath/hazard_unit.sv
      - datapath/datapath.sv
  - target: test
    files:
      - tests/datapath_assert.sv
      - tests/tb_datapath.sv
